// File: flist.f
hw/ln_pkg.sv
hw/adder_tree.sv
hw/mean_accum.sv
hw/row_buffer.sv
hw/norm_ctrl.sv
hw/norm_lanes.sv
hw/layer_norm.sv
tb/layer_norm_chk.sv
tb/tb_layer_norm.sv

// File: hw/adder_tree.sv
`timescale 1ns/1ns

module adder_tree (
    input  logic                                    clk,
    input  logic                                    rstn,
    input  ln_pkg::lane_t [ln_pkg::BUS_NUM-1:0]     data,
    input  logic                                    vld,
    output ln_pkg::acc_t                            sum,
    output logic                                    sum_vld
);

    // one register level per halving of the lane count
    localparam int LEVELS = $clog2(ln_pkg::BUS_NUM);

    // valid travels one level per clock
    logic [LEVELS-1:0] vld_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= vld;
            for (int k = 1; k < LEVELS; k++) begin
                vld_q[k] <= vld_q[k-1];
            end
        end
    end

    // pairwise adds, each level registered
    for (genvar l = 0; l < LEVELS; l++) begin : g_lvl
        localparam int N = ln_pkg::BUS_NUM >> (l + 1);

        // partial sums produced by this level
        ln_pkg::acc_t part [N];

        for (genvar j = 0; j < N; j++) begin : g_add
            if (l == 0) begin : g_leaf
                // lanes sign-extended to the accumulator width
                always_ff @(posedge clk) begin
                    part[j] <= ln_pkg::acc_t'(data[2*j]) + ln_pkg::acc_t'(data[2*j+1]);
                end
            end else begin : g_node
                // combine neighbours of the level below
                always_ff @(posedge clk) begin
                    part[j] <= g_lvl[l-1].part[2*j] + g_lvl[l-1].part[2*j+1];
                end
            end
        end
    end

    // root of the tree
    assign sum     = g_lvl[LEVELS-1].part[0];
    assign sum_vld = vld_q[LEVELS-1];

endmodule

// File: hw/layer_norm.sv
`timescale 1ns/1ns

module layer_norm #(
    parameter int ROW_BEATS = 4
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  ln_pkg::beat_t                       in_beat,
    input  logic                                in_vld,
    input  ln_pkg::shift_t                      out_shift,
    input  logic                                out_shift_vld,
    output ln_pkg::lane_t [ln_pkg::BUS_NUM-1:0] out_data,
    output logic                                out_vld,
    output logic                                out_last
);

    // beat taken in during load
    logic accept;

    // tree to accumulator
    ln_pkg::acc_t sum;
    logic         sum_vld;

    // row mean
    ln_pkg::acc_t mean;
    logic         mean_vld;

    // drain side
    logic          rd_en;
    logic          rd_last;
    ln_pkg::beat_t buf_dout;

    adder_tree i_adder_tree (
        .clk     (clk),
        .rstn    (rstn),
        .data    (in_beat.data),
        .vld     (accept),
        .sum     (sum),
        .sum_vld (sum_vld)
    );

    mean_accum #(.ROW_BEATS(ROW_BEATS)) i_mean_accum (
        .clk      (clk),
        .rstn     (rstn),
        .sum      (sum),
        .sum_vld  (sum_vld),
        .mean     (mean),
        .mean_vld (mean_vld)
    );

    // whole beat kept, gamma and beta ride along with the data
    row_buffer #(.ROW_BEATS(ROW_BEATS)) i_row_buffer (
        .clk   (clk),
        .rstn  (rstn),
        .wr_en (accept),
        .din   (in_beat),
        .rd_en (rd_en),
        .dout  (buf_dout)
    );

    norm_ctrl #(.ROW_BEATS(ROW_BEATS)) i_norm_ctrl (
        .clk      (clk),
        .rstn     (rstn),
        .in_vld   (in_vld),
        .mean_vld (mean_vld),
        .accept   (accept),
        .rd_en    (rd_en),
        .rd_last  (rd_last)
    );

    norm_lanes i_norm_lanes (
        .clk           (clk),
        .rstn          (rstn),
        .beat          (buf_dout),
        .rd_en         (rd_en),
        .rd_last       (rd_last),
        .mean          (mean),
        .out_shift     (out_shift),
        .out_shift_vld (out_shift_vld),
        .out_data      (out_data),
        .out_vld       (out_vld),
        .out_last      (out_last)
    );

endmodule

// File: hw/ln_pkg.sv
package ln_pkg;

    // lanes carried by one input beat
    localparam int BUS_NUM = 8;

    // int8 activations, gamma and beta
    localparam int LANE_W = 8;

    // row accumulator and partial sums
    localparam int ACC_W = 32;

    // output right-shift amount
    localparam int SHIFT_W = 5;

    // one activation, gamma or beta value
    typedef logic signed [LANE_W-1:0] lane_t;

    // partial sums, row sum, mean
    typedef logic signed [ACC_W-1:0] acc_t;

    // unsigned shift count
    typedef logic [SHIFT_W-1:0] shift_t;

    // one buffer entry
    // data, gamma and beta lanes side by side, lane 0 in the low bits
    typedef struct packed {
        lane_t [BUS_NUM-1:0] data;
        lane_t [BUS_NUM-1:0] gamma;
        lane_t [BUS_NUM-1:0] beta;
    } beat_t;

    // load sums the row, norm drains the buffer
    typedef enum logic {
        PH_LOAD = 1'b0,
        PH_NORM = 1'b1
    } ln_phase_e;

endpackage

// File: hw/mean_accum.sv
`timescale 1ns/1ns

module mean_accum #(
    parameter int ROW_BEATS = 4
) (
    input  logic         clk,
    input  logic         rstn,
    input  ln_pkg::acc_t sum,
    input  logic         sum_vld,
    output ln_pkg::acc_t mean,
    output logic         mean_vld
);

    localparam int CNT_W = (ROW_BEATS > 1) ? $clog2(ROW_BEATS) : 1;

    // divide by the element count of a row
    localparam int MEAN_SH = $clog2(ROW_BEATS * ln_pkg::BUS_NUM);

    logic [CNT_W-1:0] cnt;
    ln_pkg::acc_t     row_sum;

    // last beat of the row has been added
    logic row_done;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt      <= '0;
            row_sum  <= '0;
            row_done <= 1'b0;
            mean_vld <= 1'b0;
        end else begin
            mean_vld <= row_done;
            row_done <= 1'b0;
            if (row_done) begin
                // fresh start for the next row
                row_sum <= '0;
                cnt     <= '0;
            end else if (sum_vld) begin
                row_sum <= row_sum + sum;
                if (cnt == CNT_W'(ROW_BEATS - 1)) begin
                    cnt      <= '0;
                    row_done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // arithmetic shift keeps the sign of negative rows
    always_ff @(posedge clk) begin
        if (row_done) begin
            mean <= row_sum >>> MEAN_SH;
        end
    end

endmodule

// File: hw/norm_ctrl.sv
`timescale 1ns/1ns

module norm_ctrl #(
    parameter int ROW_BEATS = 4
) (
    input  logic clk,
    input  logic rstn,
    input  logic in_vld,
    input  logic mean_vld,
    output logic accept,
    output logic rd_en,
    output logic rd_last
);

    localparam int LD_W = $clog2(ROW_BEATS + 1);
    localparam int RD_W = (ROW_BEATS > 1) ? $clog2(ROW_BEATS) : 1;

    ln_pkg::ln_phase_e phase;

    // beats taken in during load
    logic [LD_W-1:0] ld_cnt;
    // reads issued during norm
    logic [RD_W-1:0] rd_cnt;
    logic            row_loaded;

    // a full row waits for its mean, extra beats are dropped
    assign row_loaded = (ld_cnt == LD_W'(ROW_BEATS));
    assign accept     = in_vld && (phase == ln_pkg::PH_LOAD) && !row_loaded;

    // drain runs back to back for the whole norm phase
    assign rd_en   = (phase == ln_pkg::PH_NORM);
    assign rd_last = rd_en && (rd_cnt == RD_W'(ROW_BEATS - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase  <= ln_pkg::PH_LOAD;
            ld_cnt <= '0;
            rd_cnt <= '0;
        end else begin
            case (phase)
                ln_pkg::PH_LOAD: begin
                    if (accept) begin
                        ld_cnt <= ld_cnt + 1'b1;
                    end
                    // mean ready, start the drain
                    if (mean_vld) begin
                        phase  <= ln_pkg::PH_NORM;
                        ld_cnt <= '0;
                        rd_cnt <= '0;
                    end
                end
                ln_pkg::PH_NORM: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_last) begin
                        phase  <= ln_pkg::PH_LOAD;
                        rd_cnt <= '0;
                    end
                end
                default: phase <= ln_pkg::PH_LOAD;
            endcase
        end
    end

endmodule

// File: hw/norm_lanes.sv
`timescale 1ns/1ns

module norm_lanes (
    input  logic                                clk,
    input  logic                                rstn,
    input  ln_pkg::beat_t                       beat,
    input  logic                                rd_en,
    input  logic                                rd_last,
    input  ln_pkg::acc_t                        mean,
    input  ln_pkg::shift_t                      out_shift,
    input  logic                                out_shift_vld,
    output ln_pkg::lane_t [ln_pkg::BUS_NUM-1:0] out_data,
    output logic                                out_vld,
    output logic                                out_last
);

    // int8 clamp limits
    localparam ln_pkg::acc_t LANE_MAX = 127;
    localparam ln_pkg::acc_t LANE_MIN = -128;

    ln_pkg::shift_t shift_q;

    // valid/last per stage, [0] lines up with buffer dout
    logic [1:0] vld_q;
    logic [1:0] last_q;

    // stage 1 results
    ln_pkg::acc_t                        prod_q [ln_pkg::BUS_NUM];
    ln_pkg::lane_t [ln_pkg::BUS_NUM-1:0] beta_q;

    function automatic ln_pkg::lane_t sat8(input ln_pkg::acc_t v);
        ln_pkg::lane_t r;
        if (v > LANE_MAX) r = 8'sd127;
        else if (v < LANE_MIN) r = -8'sd128;
        else r = v[ln_pkg::LANE_W-1:0];
        return r;
    endfunction

    // config register, holds until the next strobe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            shift_q <= '0;
        end else if (out_shift_vld) begin
            shift_q <= out_shift;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q    <= '0;
            last_q   <= '0;
            out_vld  <= 1'b0;
            out_last <= 1'b0;
        end else begin
            vld_q    <= {vld_q[0], rd_en};
            last_q   <= {last_q[0], rd_last};
            out_vld  <= vld_q[1];
            out_last <= last_q[1];
        end
    end

    // stage 1: centre on the mean and scale by gamma
    // stage 2: shift, add beta, clamp
    always_ff @(posedge clk) begin
        for (int i = 0; i < ln_pkg::BUS_NUM; i++) begin
            prod_q[i] <= (ln_pkg::acc_t'(beat.data[i]) - mean) * ln_pkg::acc_t'(beat.gamma[i]);
            out_data[i] <= sat8((prod_q[i] >>> shift_q) + ln_pkg::acc_t'(beta_q[i]));
        end
        beta_q <= beat.beta;
    end

endmodule

// File: hw/row_buffer.sv
`timescale 1ns/1ns

module row_buffer #(
    parameter int ROW_BEATS = 4
) (
    input  logic          clk,
    input  logic          rstn,
    input  logic          wr_en,
    input  ln_pkg::beat_t din,
    input  logic          rd_en,
    output ln_pkg::beat_t dout
);

    localparam int PTR_W = (ROW_BEATS > 1) ? $clog2(ROW_BEATS) : 1;

    // one row of beats
    ln_pkg::beat_t mem [ROW_BEATS];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // pointers wrap at the row length
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(ROW_BEATS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(ROW_BEATS - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // storage write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    // registered read, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the layer norm testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_layer_norm \
    --Mdir obj_dir \
    -f flist.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vtb_layer_norm
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit 1
fi

echo "simulation finished with status 0"
exit 0

// File: tb/layer_norm_chk.sv
`timescale 1ns/1ns

module layer_norm_chk (
    input logic clk,
    input logic rstn,
    input logic accept,
    input logic rd_en,
    input logic rd_last,
    input logic mean_vld,
    input logic out_vld,
    input logic out_last
);

    // cycles since reset release, stops at 4
    logic [2:0] rel_cnt;

    // drain window, from the mean strobe up to the last read
    logic in_norm;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rel_cnt <= '0;
        end else if (rel_cnt != 3'd4) begin
            rel_cnt <= rel_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_norm <= 1'b0;
        end else if (mean_vld) begin
            in_norm <= 1'b1;
        end else if (rd_last) begin
            in_norm <= 1'b0;
        end
    end

    // last flag only on a valid beat
    a_last_vld: assert property (@(posedge clk) disable iff (!rstn) out_last |-> out_vld)
        else $error("out_last high without out_vld");

    // reads back to back and no input taken while draining
    a_no_accept_norm: assert property (@(posedge clk) disable iff (!rstn)
        in_norm |-> (rd_en && !accept))
        else $error("beat accepted or read missing during the norm phase");

    // mean strobe is a single pulse
    a_mean_pulse: assert property (@(posedge clk) disable iff (!rstn) mean_vld |=> !mean_vld)
        else $error("mean_vld held longer than one cycle");

    // pipeline cannot produce anything this early
    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rstn)
        (rel_cnt < 3'd4) |-> !out_vld)
        else $error("out_vld within 4 cycles of reset release");

endmodule

bind layer_norm layer_norm_chk i_layer_norm_chk (
    .clk      (clk),
    .rstn     (rstn),
    .accept   (accept),
    .rd_en    (rd_en),
    .rd_last  (rd_last),
    .mean_vld (mean_vld),
    .out_vld  (out_vld),
    .out_last (out_last)
);

// File: tb/tb_layer_norm.sv
`timescale 1ns/1ns

module tb_layer_norm;

    localparam int ROW_BEATS    = 4;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    // log2 of the element count of a row
    localparam int MEAN_SH = $clog2(ROW_BEATS * ln_pkg::BUS_NUM);

    // rows per test section, plus one row sent twice
    localparam int RAND_ROWS = 12;
    localparam int SAT_ROWS  = 4;
    localparam int B2B_ROWS  = 6;
    localparam int NUM_ROWS  = RAND_ROWS + 2 + SAT_ROWS + B2B_ROWS;
    localparam int WATCHDOG_NS = NUM_ROWS * (ROW_BEATS + 20) * CLK_PERIOD
                                 + (RESET_CYCLES + 2) * CLK_PERIOD;

    logic                                clk;
    logic                                rstn;
    ln_pkg::beat_t                       in_beat;
    logic                                in_vld;
    ln_pkg::shift_t                      out_shift;
    logic                                out_shift_vld;
    ln_pkg::lane_t [ln_pkg::BUS_NUM-1:0] out_data;
    logic                                out_vld;
    logic                                out_last;

    // row being sent
    ln_pkg::beat_t cur_row [ROW_BEATS];

    // expected output beats, oldest first
    ln_pkg::lane_t [ln_pkg::BUS_NUM-1:0] exp_data_q [$];
    bit                                  exp_last_q [$];

    // shift value the DUT should hold
    int model_shift;
    int rows_sent;
    int rows_done;
    int row_beat_cnt;
    int beats_seen;

    layer_norm #(.ROW_BEATS(ROW_BEATS)) i_layer_norm (
        .clk           (clk),
        .rstn          (rstn),
        .in_beat       (in_beat),
        .in_vld        (in_vld),
        .out_shift     (out_shift),
        .out_shift_vld (out_shift_vld),
        .out_data      (out_data),
        .out_vld       (out_vld),
        .out_last      (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hard stop if a row never completes
    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, only %0d of %0d rows finished",
                 WATCHDOG_NS, rows_done, NUM_ROWS);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic check_val(input string name, input logic signed [31:0] exp_val,
                             input logic signed [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, exp_val, act_val);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic int clamp_to_int8(input int v);
        if (v > 127) return 127;
        if (v < -128) return -128;
        return v;
    endfunction

    // all 192 bits random, data, gamma and beta alike
    function automatic ln_pkg::beat_t random_beat();
        return ln_pkg::beat_t'({$urandom, $urandom, $urandom, $urandom, $urandom, $urandom});
    endfunction

    // mean over the whole row, then the per-lane expression
    task automatic predict_row();
        int sum;
        int mean;
        int prod;
        ln_pkg::lane_t [ln_pkg::BUS_NUM-1:0] lanes;
        sum = 0;
        for (int b = 0; b < ROW_BEATS; b++) begin
            for (int i = 0; i < ln_pkg::BUS_NUM; i++) begin
                sum += int'(cur_row[b].data[i]);
            end
        end
        mean = sum >>> MEAN_SH;
        for (int b = 0; b < ROW_BEATS; b++) begin
            for (int i = 0; i < ln_pkg::BUS_NUM; i++) begin
                prod = (int'(cur_row[b].data[i]) - mean) * int'(cur_row[b].gamma[i]);
                lanes[i] = ln_pkg::lane_t'(clamp_to_int8((prod >>> model_shift)
                                                         + int'(cur_row[b].beta[i])));
            end
            exp_data_q.push_back(lanes);
            exp_last_q.push_back(b == ROW_BEATS - 1);
        end
    endtask

    // full-range int8, gamma forced to +-127 when saturating
    task automatic fill_random_row(input bit saturate);
        for (int b = 0; b < ROW_BEATS; b++) begin
            for (int i = 0; i < ln_pkg::BUS_NUM; i++) begin
                cur_row[b].data[i] = ln_pkg::lane_t'($urandom);
                cur_row[b].beta[i] = ln_pkg::lane_t'($urandom);
                if (saturate) begin
                    cur_row[b].gamma[i] = ($urandom_range(1, 0) != 0) ? 8'sd127 : -8'sd127;
                end else begin
                    cur_row[b].gamma[i] = ln_pkg::lane_t'($urandom);
                end
            end
        end
    endtask

    // one-cycle strobe, then junk on the bus without the strobe
    task automatic set_shift(input int sh);
        @(posedge clk);
        #1;
        out_shift     = ln_pkg::shift_t'(sh);
        out_shift_vld = 1'b1;
        model_shift   = sh;
        @(posedge clk);
        #1;
        out_shift_vld = 1'b0;
        out_shift     = ln_pkg::shift_t'($urandom);
    endtask

    // drive one row, queue its expected beats, wait for out_last
    task automatic run_row();
        for (int b = 0; b < ROW_BEATS; b++) begin
            @(posedge clk);
            #1;
            in_beat = cur_row[b];
            in_vld  = 1'b1;
        end
        @(posedge clk);
        #1;
        // queued only now, so an early out_vld finds it empty
        predict_row();
        rows_sent++;
        // extra beats while the row waits and drains, all must be dropped
        while (!out_vld) begin
            in_beat = random_beat();
            @(posedge clk);
            #1;
        end
        in_vld = 1'b0;
        wait (rows_done == rows_sent);
    endtask

    task automatic check_output_beat();
        ln_pkg::lane_t [ln_pkg::BUS_NUM-1:0] exp_lanes;
        bit                                  exp_last;
        if (exp_data_q.size() == 0) begin
            $display("out_vld at %0t while no complete row was loaded", $time);
            $display("RESULT: FAIL");
            $fatal(1, "unexpected output beat");
        end else begin
            exp_lanes = exp_data_q.pop_front();
            exp_last  = exp_last_q.pop_front();
            for (int i = 0; i < ln_pkg::BUS_NUM; i++) begin
                check_val($sformatf("out_data[%0d]", i), 32'(exp_lanes[i]), 32'(out_data[i]));
            end
            check_val("out_last", 32'(exp_last), 32'(out_last));
            row_beat_cnt++;
            beats_seen++;
            if (out_last) begin
                check_val("out_vld beats in row", ROW_BEATS, row_beat_cnt);
                row_beat_cnt = 0;
                rows_done++;
            end
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            if (out_vld) begin
                check_output_beat();
            end else begin
                check_val("out_last", 0, 32'(out_last));
            end
        end
    end

    initial begin
        void'($urandom(32'h273b));
        rstn          = 1'b0;
        in_beat       = '0;
        in_vld        = 1'b0;
        out_shift     = '0;
        out_shift_vld = 1'b0;
        model_shift   = 0;
        rows_sent     = 0;
        rows_done     = 0;
        row_beat_cnt  = 0;
        beats_seen    = 0;
        // outputs quiet while in reset
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_val("out_vld", 0, 32'(out_vld));
            check_val("out_last", 0, 32'(out_last));
        end
        @(posedge clk);
        #1;
        rstn = 1'b1;
        // random rows with a fresh shift each
        for (int r = 0; r < RAND_ROWS; r++) begin
            set_shift($urandom_range(10, 0));
            fill_random_row(1'b0);
            run_row();
        end
        // same row under two shifts
        fill_random_row(1'b0);
        set_shift(2);
        run_row();
        set_shift(7);
        run_row();
        // gamma at the limits, no shift
        set_shift(0);
        for (int r = 0; r < SAT_ROWS; r++) begin
            fill_random_row(1'b1);
            run_row();
        end
        // back to back right after each out_last
        set_shift($urandom_range(10, 0));
        for (int r = 0; r < B2B_ROWS; r++) begin
            fill_random_row(1'b0);
            run_row();
        end
        // idle tail, nothing more may come out
        repeat (10) @(posedge clk);
        check_val("pending expected beats", 0, exp_data_q.size());
        check_val("out_vld beat count", NUM_ROWS * ROW_BEATS, beats_seen);
        $display("RESULT: PASS");
        $finish;
    end

endmodule
